// File: apu_frame_top.f
src/apu_frame_pkg.sv
src/frame_seq_if.sv
src/clk_divider.sv
src/aclk_gen.sv
src/frame_lfsr.sv
src/frame_decode.sv
src/frame_control.sv
src/apu_frame_top.sv
verif/apu_frame_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the frame sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module apu_frame_tb \
	-f apu_frame_top.f -o apu_frame_sim || exit 1

out=$(./obj_dir/apu_frame_sim)
echo "$out"

echo "$out" | grep -qx "RESULT: PASS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: verif/apu_frame_tb.sv
`timescale 1ns/1ps

module apu_frame_tb;

	import apu_frame_pkg::*;

	typedef struct packed {
		logic mode;
		logic inhibit;
		logic do_read;
		logic dmc;
		int exp_q;
		int exp_h;
		logic exp_flag;
	} entry_t;

	localparam int num_tests = 7;
	localparam int margin_ticks = 20;
	localparam int clks_per_tick = 12; // Two CPU cycles of six clks
	localparam int tick_table [5] = '{3728, 7456, 11185, 14914, 18640};

	// mode, inhibit, read, dmc, quarter, half, flag
	entry_t tests [num_tests] = '{
		'{1'b0, 1'b0, 1'b0, 1'b0, 4, 2, 1'b1},
		'{1'b0, 1'b0, 1'b1, 1'b0, 4, 2, 1'b1},
		'{1'b1, 1'b0, 1'b0, 1'b0, 5, 3, 1'b0},
		'{1'b0, 1'b1, 1'b0, 1'b0, 4, 2, 1'b0},
		'{1'b0, 1'b0, 1'b0, 1'b0, 4, 2, 1'b1},
		'{1'b0, 1'b1, 1'b0, 1'b0, 4, 2, 1'b0},
		'{1'b1, 1'b1, 1'b1, 1'b1, 5, 3, 1'b0}
	};
	string names [num_tests] = '{"mode0_irq", "mode0_read", "mode1_no_irq", "mode0_inhibit",
		"mode0_flag_set", "inhibit_clears", "dmc_only"};

	logic clk;
	logic reset;
	logic phi2_core;
	logic wr_frame;
	logic rd_status;
	reg_data_t wdata;
	logic dmc_irq;
	logic cpu_en;
	logic m2;
	logic quarter_frame;
	logic half_frame;
	logic irq;
	logic status_irq;

	int cpu_cnt = 0;
	int q_cnt = 0;
	int h_cnt = 0;
	int stamps [$]; // cpu_en count at each quarter pulse
	int stage = 0;
	int mon_errs = 0;
	int errors = 0;
	int cycle_cnt = 0;
	int limit = 0;
	int phi_cnt = 0;

	apu_frame_top UUT (
		.clk(clk),
		.reset(reset),
		.phi2_core(phi2_core),
		.wr_frame(wr_frame),
		.rd_status(rd_status),
		.wdata(wdata),
		.dmc_irq(dmc_irq),
		.cpu_en(cpu_en),
		.m2(m2),
		.quarter_frame(quarter_frame),
		.half_frame(half_frame),
		.irq(irq),
		.status_irq(status_irq)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Low one cycle in five, so the m2 gate is seen in every ring stage
	initial begin
		phi2_core = 1'b1;
		forever begin
			@(posedge clk);
			#5;
			phi_cnt++;
			phi2_core = (phi_cnt % 5) != 2;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (limit > 0 && cycle_cnt > limit) begin
			$display("timeout: run still going after %0d clock cycles", cycle_cnt);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// Expected ring position, last stage carries cpu_en
	always @(posedge clk) begin
		if (reset) begin
			stage <= 0;
		end else begin
			stage <= (stage + 1) % CPU_DIV;
		end
	end

	always @(negedge clk) begin
		if (!reset) begin
			if (cpu_en) begin
				cpu_cnt++;
			end
			if (quarter_frame) begin
				stamps.push_back(cpu_cnt);
				q_cnt++;
			end
			if (half_frame) begin
				h_cnt++;
			end
			if (mon_errs < 4) begin
				check_bit("clock.cpu_en", stage == CPU_DIV - 1, cpu_en, mon_errs);
				check_bit("clock.m2", stage >= CPU_DIV / 2 && phi2_core, m2, mon_errs);
			end
		end
	end

	task automatic check_count(input string name, input int expected, input int actual,
		inout int errs);
		if (expected !== actual) begin
			$display("FAILED %s expected %0d actual %0d", name, expected, actual);
			errs++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual,
		inout int errs);
		if (expected !== actual) begin
			$display("FAILED %s expected %b actual %b", name, expected, actual);
			errs++;
		end
	endtask

	task automatic check_lfsr_period(input string name, input lfsr_t expected,
		input lfsr_t actual, inout int errs);
		if (expected !== actual) begin
			$display("FAILED %s expected %h actual %h", name, expected, actual);
			errs++;
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	task automatic wait_ticks(input int from_cnt, input int ticks);
		while (cpu_cnt - from_cnt < 2 * ticks) begin
			@(posedge clk);
		end
		#5;
	endtask

	// Step 3 is skipped in the 5-step sequence
	function automatic int step_index(input logic mode, input int j);
		return (mode && j == 3) ? 4 : j;
	endfunction

	task automatic recount_step_states();
		lfsr_t s;
		int k;
		s = '0;
		k = 0;
		for (int t = 1; t <= tick_table[4]; t++) begin
			s = {s[13:0], ~(s[13] ^ s[14])};
			if (t == tick_table[k]) begin
				check_lfsr_period($sformatf("step_states.%0d", k), s, STEP_STATE[k], errors);
				k++;
			end
		end
	endtask

	task automatic run_entry(input int i);
		entry_t e;
		string name;
		int errs_before;
		int cpu_start;
		int q_start;
		int h_start;
		int seq_ticks;
		int first;
		int n_steps;
		int exp_gap;
		int act_gap;
		e = tests[i];
		name = names[i];
		errs_before = errors;
		seq_ticks = (e.mode ? tick_table[4] : tick_table[3]) + 1;
		repeat ($urandom_range(40, 1)) next_cycle();
		dmc_irq = e.dmc;
		cpu_start = cpu_cnt;
		q_start = q_cnt;
		h_start = h_cnt;
		wr_frame = 1'b1;
		wdata = {e.mode, e.inhibit, 6'b000000};
		next_cycle();
		wr_frame = 1'b0;
		wdata = '0;
		if (e.inhibit) begin
			@(negedge clk);
			check_bit({name, ".irq_after_write"}, e.dmc, irq, errors);
		end
		wait_ticks(cpu_start, seq_ticks + margin_ticks);
		check_count({name, ".quarter"}, e.exp_q, q_cnt - q_start, errors);
		check_count({name, ".half"}, e.exp_h, h_cnt - h_start, errors);
		first = q_start + (e.mode ? 1 : 0); // Skip the pulse of the write itself
		n_steps = q_cnt - first;
		for (int j = 0; j + 1 < n_steps && j < 3; j++) begin
			exp_gap = tick_table[step_index(e.mode, j + 1)] - tick_table[step_index(e.mode, j)];
			act_gap = (stamps[first + j + 1] - stamps[first + j]) / 2;
			check_count($sformatf("%s.gap%0d", name, j), exp_gap, act_gap, errors);
		end
		@(negedge clk);
		check_bit({name, ".irq"}, e.exp_flag | e.dmc, irq, errors);
		if (e.do_read) begin
			next_cycle();
			rd_status = 1'b1;
			@(negedge clk);
			check_bit({name, ".status_irq"}, e.exp_flag, status_irq, errors);
			next_cycle();
			rd_status = 1'b0;
			@(negedge clk);
			check_bit({name, ".irq_after_read"}, e.dmc, irq, errors);
		end
		if (e.dmc) begin
			next_cycle();
			dmc_irq = 1'b0;
			@(negedge clk);
			check_bit({name, ".irq_dmc_released"}, e.exp_flag & ~e.do_read, irq, errors);
		end
		$display("test %s done with %0d error(s)", name, errors - errs_before);
	endtask

	initial begin
		int entry_clks;
		reset = 1'b1;
		wr_frame = 1'b0;
		rd_status = 1'b0;
		wdata = '0;
		dmc_irq = 1'b0;
		void'($urandom(84147));
		for (int i = 0; i < num_tests; i++) begin
			entry_clks = (tests[i].mode ? tick_table[4] : tick_table[3]) + 1 + margin_ticks;
			limit += entry_clks * clks_per_tick;
		end
		limit += limit / 10;
		repeat (4) @(posedge clk);
		#5;
		reset = 1'b0;
		recount_step_states();
		$display("test step_states done with %0d error(s)", errors);
		for (int i = 0; i < num_tests; i++) begin
			run_entry(i);
		end
		$display("test clock_monitor done with %0d error(s)", mon_errs);
		$display("%0d tests run, %0d errors in total", num_tests + 2, errors + mon_errs);
		if (errors + mon_errs == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: src/apu_frame_top.sv
`timescale 1ns/1ps

module apu_frame_top (
	input logic clk,
	input logic reset,
	input logic phi2_core,
	input logic wr_frame,
	input logic rd_status,
	input apu_frame_pkg::reg_data_t wdata,
	input logic dmc_irq,
	output logic cpu_en,
	output logic m2,
	output logic quarter_frame,
	output logic half_frame,
	output logic irq,
	output logic status_irq
);

	logic apu_en;

	frame_seq_if seq ();

	clk_divider u_clk_divider (
		.clk(clk),
		.reset(reset),
		.phi2_core(phi2_core),
		.cpu_en(cpu_en),
		.m2(m2)
	);

	aclk_gen u_aclk_gen (
		.clk(clk),
		.reset(reset),
		.cpu_en(cpu_en),
		.apu_en(apu_en)
	);

	// Soft timer
	frame_lfsr u_frame_lfsr (
		.clk(clk),
		.reset(reset),
		.apu_en(apu_en),
		.seq(seq.lfsr)
	);

	frame_decode u_frame_decode (
		.seq(seq.decode)
	);

	frame_control u_frame_control (
		.clk(clk),
		.reset(reset),
		.apu_en(apu_en),
		.wr_frame(wr_frame),
		.rd_status(rd_status),
		.wdata(wdata),
		.dmc_irq(dmc_irq),
		.seq(seq.control),
		.quarter_frame(quarter_frame),
		.half_frame(half_frame),
		.irq(irq),
		.status_irq(status_irq)
	);

endmodule

// File: src/frame_control.sv
`timescale 1ns/1ps

module frame_control (
	input logic clk,
	input logic reset,
	input logic apu_en,
	input logic wr_frame,
	input logic rd_status,
	input apu_frame_pkg::reg_data_t wdata,
	input logic dmc_irq,
	frame_seq_if.control seq,
	output logic quarter_frame,
	output logic half_frame,
	output logic irq,
	output logic status_irq
);

	import apu_frame_pkg::*;

	logic pend_wr;
	logic pend_mode;
	logic pend_inhibit;
	logic mode;
	logic inhibit;
	logic irq_flag;
	logic wr_pulse;
	logic want_quarter;
	logic want_half;
	logic set_flag;
	logic clr_flag;

	// Write waits here until the next apu_en
	always_ff @(posedge clk) begin
		if (reset) begin
			pend_wr <= 1'b0;
		end else if (wr_frame) begin
			pend_wr <= 1'b1;
		end else if (apu_en) begin
			pend_wr <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_frame) begin
			pend_mode <= wdata[MODE_BIT];
			pend_inhibit <= wdata[INHIBIT_BIT];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= 1'b0;
			inhibit <= 1'b0;
		end else if (apu_en && pend_wr) begin
			mode <= pend_mode;
			inhibit <= pend_inhibit;
		end
	end

	// A 5-step write clocks both units at once
	assign wr_pulse = pend_wr & pend_mode;

	assign want_quarter = (|seq.step) | wr_pulse;
	assign want_half = seq.step[1] | seq.step[3] | seq.step[4] | wr_pulse;

	// Pending inhibit already blocks the flag
	assign set_flag = seq.step[3] & ~inhibit & ~(pend_wr & pend_inhibit);
	assign clr_flag = rd_status | (wr_frame & wdata[INHIBIT_BIT]);

	always_ff @(posedge clk) begin
		if (reset) begin
			irq_flag <= 1'b0;
		end else if (clr_flag) begin
			irq_flag <= 1'b0;
		end else if (apu_en && set_flag) begin
			irq_flag <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			quarter_frame <= 1'b0;
			half_frame <= 1'b0;
		end else begin
			quarter_frame <= apu_en & want_quarter;
			half_frame <= apu_en & want_half;
		end
	end

	assign seq.mode = mode;
	assign seq.reload = pend_wr | seq.step[3] | seq.step[4]; // Write or last step

	assign irq = irq_flag | dmc_irq;
	assign status_irq = rd_status & irq_flag;

	half_has_quarter: assert property (
		@(posedge clk) disable iff (reset)
		half_frame |-> quarter_frame
	) else $error("half frame without quarter frame");

	inhibit_keeps_flag_clear: assert property (
		@(posedge clk) disable iff (reset)
		inhibit |-> !irq_flag
	) else $error("frame flag set while inhibited");

endmodule

// File: src/frame_decode.sv
`timescale 1ns/1ps

module frame_decode (
	frame_seq_if.decode seq
);

	import apu_frame_pkg::*;

	step_t hit;
	step_t step;

	// Raw state matches, one per step
	always_comb begin
		hit = '0;
		for (int k = 0; k < STEPS; k++) begin
			hit[k] = (seq.state == STEP_STATE[k]);
		end
	end

	// Step 3 ends the 4-step sequence, step 4 the 5-step one
	always_comb begin
		step = hit;
		step[3] = hit[3] & ~seq.mode;
		step[4] = hit[4] & seq.mode;
	end

	assign seq.step = step;

endmodule

// File: src/frame_lfsr.sv
`timescale 1ns/1ps

module frame_lfsr (
	input logic clk,
	input logic reset,
	input logic apu_en,
	frame_seq_if.lfsr seq
);

	import apu_frame_pkg::*;

	lfsr_t state;
	lfsr_t shifted;
	logic locked;

	assign shifted = lfsr_next(state);

	// All ones maps onto itself under XNOR feedback
	assign locked = &state;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= LFSR_SEED;
		end else if (apu_en) begin
			if (seq.reload || locked) begin
				state <= LFSR_SEED;
			end else begin
				state <= shifted;
			end
		end
	end

	assign seq.state = state;

endmodule

// File: src/aclk_gen.sv
`timescale 1ns/1ps

module aclk_gen (
	input logic clk,
	input logic reset,
	input logic cpu_en,
	output logic apu_en
);

	logic phase;

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= 1'b0;
		end else if (cpu_en) begin
			phase <= ~phase; // Toggle per CPU cycle
		end
	end

	// Second CPU cycle of each pair
	assign apu_en = cpu_en & phase;

	apu_en_in_cpu_cycle: assert property (
		@(posedge clk) disable iff (reset)
		apu_en |-> cpu_en
	) else $error("apu_en outside a CPU cycle");

endmodule

// File: src/clk_divider.sv
`timescale 1ns/1ps

module clk_divider (
	input logic clk,
	input logic reset,
	input logic phi2_core,
	output logic cpu_en,
	output logic m2
);

	import apu_frame_pkg::*;

	logic [CPU_DIV-1:0] ring;
	logic ring_high;

	// One-hot ring, one stage per clk
	always_ff @(posedge clk) begin
		if (reset) begin
			ring <= {{(CPU_DIV-1){1'b0}}, 1'b1};
		end else begin
			ring <= {ring[CPU_DIV-2:0], ring[CPU_DIV-1]};
		end
	end

	assign cpu_en = ring[CPU_DIV-1]; // Last stage

	// Bus clock is high over the second half of the CPU cycle
	assign ring_high = |ring[CPU_DIV-1:CPU_DIV/2];
	assign m2 = ring_high & phi2_core;

	ring_onehot: assert property (
		@(posedge clk) disable iff (reset)
		$onehot(ring)
	) else $error("divider ring lost its single token");

endmodule

// File: src/frame_seq_if.sv
`timescale 1ns/1ps

interface frame_seq_if;

	import apu_frame_pkg::*;

	lfsr_t state; // Current LFSR state
	step_t step; // Decoded step, already mode gated
	logic mode;
	logic reload; // Load seed on next apu_en

	modport lfsr (
		output state,
		input reload
	);

	modport decode (
		input state,
		input mode,
		output step
	);

	modport control (
		input step,
		output mode,
		output reload
	);

endinterface

// File: src/apu_frame_pkg.sv
package apu_frame_pkg;

	localparam int CPU_DIV = 6; // clk cycles per CPU cycle
	localparam int LFSR_W = 15;
	localparam int STEPS = 5;

	typedef logic [LFSR_W-1:0] lfsr_t;
	typedef logic [STEPS-1:0] step_t;
	typedef logic [7:0] reg_data_t;

	localparam lfsr_t LFSR_SEED = '0;

	localparam int MODE_BIT = 7; // 5-step sequence when set
	localparam int INHIBIT_BIT = 6; // Frame IRQ inhibit

	// Ticks after reload at which each step fires
	localparam int STEP_TICKS [STEPS] = '{3728, 7456, 11185, 14914, 18640};

	// Shift left, XNOR of the two top bits fed back into bit 0
	function automatic lfsr_t lfsr_next(input lfsr_t s);
		return {s[LFSR_W-2:0], ~(s[LFSR_W-2] ^ s[LFSR_W-1])};
	endfunction

	function automatic lfsr_t lfsr_after(input int ticks);
		lfsr_t s;
		int left;
		int burst;
		s = LFSR_SEED;
		left = ticks;
		while (left > 0) begin
			burst = (left > 1000) ? 1000 : left; // Walk in bursts
			for (int i = 0; i < burst; i++) begin
				s = lfsr_next(s);
			end
			left -= burst;
		end
		return s;
	endfunction

	localparam lfsr_t STEP_STATE [STEPS] = '{
		lfsr_after(STEP_TICKS[0]),
		lfsr_after(STEP_TICKS[1]),
		lfsr_after(STEP_TICKS[2]),
		lfsr_after(STEP_TICKS[3]),
		lfsr_after(STEP_TICKS[4])
	};

endpackage
